// File: compile.f
+incdir+rtl
rtl/eeprom_pkg.sv
rtl/eeprom_bus_ctrl.sv
rtl/eeprom_bank.sv
rtl/eeprom_read_mux.sv
rtl/eeprom_top.sv
tb/eeprom_clock_gen.sv
tb/eeprom_sva.sv
tb/eeprom_tb.sv

// File: Bender.yml
package:
  name: eeprom

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/eeprom_pkg.sv
      - rtl/eeprom_bus_ctrl.sv
      - rtl/eeprom_bank.sv
      - rtl/eeprom_read_mux.sv
      - rtl/eeprom_top.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - tb/eeprom_clock_gen.sv
      - tb/eeprom_sva.sv
      - tb/eeprom_tb.sv

// File: tb/eeprom_tb.sv
`timescale 1ns/1ns
`default_nettype none
`include "eeprom_config.svh"

module eeprom_tb;

    localparam int BIT_CYCLES    = 20;
    localparam int SEQ_BYTES     = 90;   // Bytes on the wire over all five sequences
    localparam int SEQ_MARKS     = 58;   // Starts and stops take no more than two bit times each
    localparam int MARGIN_CYCLES = 1000;
    localparam logic [1:0] KIND_DATA    = 2'd0;
    localparam logic [1:0] KIND_ACK     = 2'd1;
    localparam logic [1:0] KIND_RELEASE = 2'd2;

    typedef struct packed {
        logic [1:0]  kind;
        logic [10:0] addr;
        logic [7:0]  got;
        logic        exp_bit;
        logic        got_bit;
    } obs_t;

    logic        sda;
    logic        reset;
    logic        scl;
    logic        sdata_m;   // Master drive where 1 releases the line
    logic        line;
    logic        sdata_pull;
    integer      seed = 32'hae39_8317;
    logic [7:0]  ref_mem [logic [10:0]];
    logic [10:0] cur_addr;
    obs_t        obs_q [$];
    int          checks_posted = 0;
    int          checks_done = 0;

    eeprom_clock_gen u_clock_gen (
        .sda   (sda),
        .reset (reset)
    );

    // The line stays high while the pull is still unknown before reset
    assign line = sdata_m & (sdata_pull !== 1'b1);

    eeprom_top u_eeprom_top (
        .sda        (sda),
        .reset      (reset),
        .scl        (scl),
        .sdata      (line),
        .sdata_pull (sdata_pull)
    );

    bind eeprom_top eeprom_sva u_sva (
        .sda        (sda),
        .reset      (reset),
        .sdata_pull (sdata_pull),
        .mem_write  (mem_req.write),
        .load       (load),
        .shift      (shift)
    );

    function automatic logic [7:0] expected_byte(input logic [10:0] addr, output logic written);
        written = (ref_mem.exists(addr) != 0);
        expected_byte = written ? ref_mem[addr] : 8'h00;
    endfunction

    // In-bank address wraps and the bank stays
    function automatic logic [10:0] next_addr(input logic [10:0] addr);
        next_addr = {addr[10:8], addr[7:0] + 8'd1};
    endfunction

    function automatic logic [7:0] ctrl_byte(input logic [3:0] dev, input logic [2:0] bank,
                                             input logic rd);
        ctrl_byte = {dev, bank, rd};
    endfunction

    task automatic wait_drive(input int cycles);
        repeat (cycles) @(posedge sda);
        #10;
    endtask

    task automatic post_check(input logic [1:0] kind, input logic [10:0] addr,
                              input logic [7:0] got, input logic exp_bit, input logic got_bit);
        obs_t ev;
        ev.kind    = kind;
        ev.addr    = addr;
        ev.got     = got;
        ev.exp_bit = exp_bit;
        ev.got_bit = got_bit;
        obs_q.push_back(ev);
        checks_posted++;
    endtask

    task automatic clock_bit(input logic b, output logic level);
        wait_drive(5);
        sdata_m = b;
        wait_drive(5);
        scl = 1'b1;
        wait_drive(5);
        level = line;   // Middle of the high phase
        wait_drive(5);
        scl = 1'b0;
    endtask

    task automatic bus_start();
        if (scl == 1'b0)
        begin
            wait_drive(5);
            sdata_m = 1'b1;
            wait_drive(5);
            scl = 1'b1;
            wait_drive(10);
        end
        sdata_m = 1'b0;
        wait_drive(10);
        scl = 1'b0;
    endtask

    task automatic bus_stop();
        wait_drive(5);
        sdata_m = 1'b0;
        wait_drive(5);
        scl = 1'b1;
        wait_drive(10);
        sdata_m = 1'b1;
        wait_drive(10);
    endtask

    task automatic send_byte(input logic [7:0] b, input logic exp_ack);
        logic level;
        for (int i = 7; i >= 0; i--)
        begin
            clock_bit(b[i], level);
        end
        clock_bit(1'b1, level);
        post_check(KIND_ACK, cur_addr, b, exp_ack, ~level);
    endtask

    task automatic recv_byte(input logic ack);
        logic       level;
        logic [7:0] b;
        b = 8'h00;
        for (int i = 0; i < 8; i++)
        begin
            clock_bit(1'b1, level);
            b = {b[6:0], level};
        end
        clock_bit(~ack, level);
        post_check(KIND_DATA, cur_addr, b, 1'b0, 1'b0);
        cur_addr = next_addr(cur_addr);
    endtask

    task automatic read_bytes(input int count);
        for (int k = 0; k < count; k++)
        begin
            recv_byte(k < count - 1);   // Last byte gets a not-acknowledge
        end
    endtask

    task automatic write_seq(input logic [10:0] addr, input int count);
        logic [7:0] d;
        bus_start();
        cur_addr = addr;
        send_byte(ctrl_byte(`EEPROM_DEVICE_TYPE, addr[10:8], 1'b0), 1'b1);
        send_byte(addr[7:0], 1'b1);
        for (int k = 0; k < count; k++)
        begin
            d = 8'($random(seed));
            send_byte(d, 1'b1);
            ref_mem[cur_addr] = d;
            cur_addr = next_addr(cur_addr);
        end
        bus_stop();
    endtask

    // Random read that leaves the closing stop to the caller
    task automatic read_at(input logic [10:0] addr, input int count);
        bus_start();
        send_byte(ctrl_byte(`EEPROM_DEVICE_TYPE, addr[10:8], 1'b0), 1'b1);
        send_byte(addr[7:0], 1'b1);
        cur_addr = addr;
        bus_start();
        send_byte(ctrl_byte(`EEPROM_DEVICE_TYPE, addr[10:8], 1'b1), 1'b1);
        read_bytes(count);
    endtask

    task automatic current_read(input int count);
        bus_start();
        send_byte(ctrl_byte(`EEPROM_DEVICE_TYPE, cur_addr[10:8], 1'b1), 1'b1);
        read_bytes(count);
        bus_stop();
    endtask

    initial
    begin : compare
        obs_t       ev;
        logic [7:0] want;
        logic       written;
        forever
        begin
            wait (checks_done != checks_posted);
            while (obs_q.size() > 0)
            begin
                ev = obs_q.pop_front();
                if (ev.kind == KIND_DATA)
                begin
                    want = expected_byte(ev.addr, written);
                    assert (written)
                    else
                    begin
                        $display("ERROR: the sequence read address %h that was never written",
                                 ev.addr);
                        $display("Checks failed");
                        $fatal(1);
                    end
                    assert (ev.got === want)
                    else
                    begin
                        $display("CHECK FAILED at %0t ns: byte read from %h is %h, expected %h",
                                 $time, ev.addr, ev.got, want);
                        $display("Checks failed");
                        $fatal(1);
                    end
                end
                else
                begin
                    assert (ev.got_bit === ev.exp_bit)
                    else
                    begin
                        $display("CHECK FAILED at %0t ns: %s is %b, expected %b", $time,
                                 (ev.kind == KIND_ACK) ? "acknowledge" : "sdata_pull after NACK",
                                 ev.got_bit, ev.exp_bit);
                        $display("Checks failed");
                        $fatal(1);
                    end
                end
                checks_done++;
            end
        end
    end

    initial
    begin : assertion_watch
        wait (u_eeprom_top.u_sva.error_count != 0);
        $display("ERROR: a bound assertion on the DUT failed at %0t ns", $time);
        $display("Checks failed");
        $fatal(1);
    end

    initial
    begin : watchdog
        repeat ((SEQ_BYTES * 9 + SEQ_MARKS * 2) * BIT_CYCLES + MARGIN_CYCLES) @(posedge sda);
        $display("ERROR: run timed out at %0t ns before the bus sequences finished", $time);
        $display("Checks failed");
        $fatal(1);
    end

    initial
    begin : stimulus
        logic [10:0] first_addr [8];
        logic [10:0] wrap_addr;
        scl      = 1'b1;
        sdata_m  = 1'b1;
        cur_addr = '0;
        wait (reset == 1'b0);
        wait_drive(10);

        for (int b = 0; b < 8; b++)
        begin
            first_addr[b] = {3'(b), 8'($random(seed))};
            write_seq(first_addr[b], 1);
            read_at(first_addr[b], 1);
            bus_stop();
        end

        // Six bytes from 252 run over the bank end to 0 and 1
        wrap_addr = {3'($random(seed)), 8'd252};
        write_seq(wrap_addr, 6);
        read_at(wrap_addr, 6);
        bus_stop();

        // A wrong device type keeps everything after it out of the memory
        bus_start();
        send_byte(ctrl_byte(4'b1011, wrap_addr[10:8], 1'b0), 1'b0);
        send_byte(wrap_addr[7:0], 1'b0);
        send_byte(8'($random(seed)), 1'b0);
        bus_stop();
        read_at(wrap_addr, 1);
        bus_stop();

        bus_start();
        send_byte(ctrl_byte(`EEPROM_DEVICE_TYPE, first_addr[0][10:8], 1'b0), 1'b1);
        send_byte(first_addr[0][7:0], 1'b1);
        bus_stop();
        cur_addr = first_addr[0];
        current_read(1);

        // The line has to stay free between the NACK and the next start
        read_at(next_addr(wrap_addr), 1);
        repeat (3)
        begin
            wait_drive(3);
            post_check(KIND_RELEASE, cur_addr, 8'h00, 1'b0, sdata_pull);
        end
        current_read(1);

        wait_drive(1);
        if ((checks_posted > 0) && (checks_done == checks_posted))
        begin
            $display("All checks passed");
            $finish;
        end
        else
        begin
            $display("ERROR: %0d of %0d posted checks were never compared",
                     checks_posted - checks_done, checks_posted);
            $display("Checks failed");
            $fatal(1);
        end
    end

endmodule

`default_nettype wire

// File: tb/eeprom_sva.sv
`timescale 1ns/1ns
`default_nettype none

module eeprom_sva (
    input logic sda,
    input logic reset,
    input logic sdata_pull,
    input logic mem_write,
    input logic load,
    input logic shift
);

    logic reset_q = 1'b0;
    int   error_count = 0;   // Count of failed assertions

    always @(posedge sda)
    begin
        reset_q <= reset;   // The first reset edge has to pass before the pull is defined
    end

    a_pull_in_reset: assert property (@(posedge sda) (reset && reset_q) |-> !sdata_pull)
        else
        begin
            error_count++;
            $error("sdata_pull is active while reset is held");
        end

    // A write strobe never stretches into a second cycle
    a_write_pulse: assert property (@(posedge sda) disable iff (reset)
                                    mem_write |=> !mem_write)
        else
        begin
            error_count++;
            $error("Memory write strobe lasted more than one cycle");
        end

    a_load_shift: assert property (@(posedge sda) disable iff (reset) !(load && shift))
        else
        begin
            error_count++;
            $error("load and shift were high in the same cycle");
        end

endmodule

`default_nettype wire

// File: tb/eeprom_clock_gen.sv
`timescale 1ns/1ns
`default_nettype none

module eeprom_clock_gen (
    output logic sda,
    output logic reset
);

    initial
    begin
        sda = 1'b0;
        forever #50 sda = ~sda;
    end

    // Released a little after the fourth rising edge
    initial
    begin
        reset = 1'b1;
        repeat (4) @(posedge sda);
        #10 reset = 1'b0;
    end

endmodule

`default_nettype wire

// File: rtl/eeprom_top.sv
`timescale 1ns/1ns
`default_nettype none
`include "eeprom_config.svh"

module eeprom_top (
    input  logic sda,
    input  logic reset,
    input  logic scl,
    input  logic sdata,        // Resolved line level, formed outside
    output logic sdata_pull    // High pulls the line low
);

    eeprom_pkg::mem_req_t                            mem_req;
    logic                                            load;
    logic                                            shift;
    logic                                            tx_bit;
    logic [`EEPROM_BANKS-1:0][`EEPROM_BYTE_BITS-1:0] bank_data;

    eeprom_bus_ctrl u_bus_ctrl (
        .sda        (sda),
        .reset      (reset),
        .scl        (scl),
        .sdata      (sdata),
        .tx_bit     (tx_bit),
        .mem_req    (mem_req),
        .load       (load),
        .shift      (shift),
        .sdata_pull (sdata_pull)
    );

    // Bank number forms the upper three address bits
    for (genvar i = 0; i < `EEPROM_BANKS; i++)
    begin : g_bank
        eeprom_bank #(
            .BANK_INDEX (i)
        ) u_bank (
            .sda     (sda),
            .mem_req (mem_req),
            .rd_data (bank_data[i])
        );
    end

    eeprom_read_mux u_read_mux (
        .sda       (sda),
        .reset     (reset),
        .mem_req   (mem_req),
        .bank_data (bank_data),
        .load      (load),
        .shift     (shift),
        .tx_bit    (tx_bit)
    );

endmodule

`default_nettype wire

// File: rtl/eeprom_read_mux.sv
`timescale 1ns/1ns
`default_nettype none
`include "eeprom_config.svh"

module eeprom_read_mux (
    input  logic                                             sda,
    input  logic                                             reset,
    input  eeprom_pkg::mem_req_t                             mem_req,
    input  logic [`EEPROM_BANKS-1:0][`EEPROM_BYTE_BITS-1:0]  bank_data,
    input  logic                                             load,
    input  logic                                             shift,
    output logic                                             tx_bit
);

    logic [`EEPROM_BYTE_BITS-1:0] sel_byte;
    logic [`EEPROM_BYTE_BITS-1:0] shift_reg;

    assign sel_byte = bank_data[mem_req.bank];

    always_ff @(posedge sda)
    begin
        if (reset)
        begin
            shift_reg <= '0;
        end
        else if (load)
        begin
            shift_reg <= sel_byte;
        end
        else if (shift)
        begin
            shift_reg <= {shift_reg[`EEPROM_BYTE_BITS-2:0], 1'b0};   // Next bit to the top
        end
    end

    // Most significant bit goes out first
    assign tx_bit = shift_reg[`EEPROM_BYTE_BITS-1];

endmodule

`default_nettype wire

// File: rtl/eeprom_bank.sv
`timescale 1ns/1ns
`default_nettype none
`include "eeprom_config.svh"

module eeprom_bank #(
    parameter int BANK_INDEX = 0
) (
    input  logic                         sda,
    input  eeprom_pkg::mem_req_t         mem_req,
    output logic [`EEPROM_BYTE_BITS-1:0] rd_data
);

    logic [`EEPROM_BYTE_BITS-1:0] mem [`EEPROM_BANK_DEPTH];
    logic                         bank_hit;

    assign bank_hit = (mem_req.bank == (`EEPROM_BANK_BITS)'(BANK_INDEX));

    always_ff @(posedge sda)
    begin
        if (mem_req.write && bank_hit)
        begin
            mem[mem_req.addr] <= mem_req.wdata;
        end
    end

    // Read runs every cycle whatever the bank field says, the selector picks later
    always_ff @(posedge sda)
    begin
        rd_data <= mem[mem_req.addr];
    end

endmodule

`default_nettype wire

// File: rtl/eeprom_bus_ctrl.sv
`timescale 1ns/1ns
`default_nettype none
`include "eeprom_config.svh"

module eeprom_bus_ctrl (
    input  logic                 sda,
    input  logic                 reset,
    input  logic                 scl,
    input  logic                 sdata,
    input  logic                 tx_bit,
    output eeprom_pkg::mem_req_t mem_req,
    output logic                 load,
    output logic                 shift,
    output logic                 sdata_pull
);

    typedef enum logic [2:0] {
        st_idle,
        st_control,
        st_address,
        st_write_data,
        st_read_data,
        st_read_ack
    } state_t;

    state_t                         state;
    logic [`EEPROM_SYNC_STAGES-1:0] scl_sync;
    logic [`EEPROM_SYNC_STAGES-1:0] sdata_sync;
    logic                           scl_s;
    logic                           sdata_s;
    logic                           scl_q;
    logic                           sdata_q;
    logic                           scl_rise;
    logic                           scl_fall;
    logic                           start_seen;
    logic                           stop_seen;
    logic [3:0]                     bit_cnt;
    eeprom_pkg::shift_word_t        rx_word;
    eeprom_pkg::shift_word_t        next_word;
    logic                           receiving;
    logic                           byte_done;
    logic                           device_ok;
    logic                           ctrl_valid;
    logic                           ack_now;
    logic                           ack_pull;
    logic                           master_ack;
    logic                           write_q;
    logic [`EEPROM_BANK_BITS-1:0]   bank_q;
    logic [`EEPROM_ADDR_BITS-1:0]   addr_q;
    logic [`EEPROM_BYTE_BITS-1:0]   wdata_q;

    // Idle bus level is high, so the synchronizers come out of reset at one
    always_ff @(posedge sda)
    begin
        if (reset)
        begin
            scl_sync   <= '1;
            sdata_sync <= '1;
            scl_q      <= 1'b1;
            sdata_q    <= 1'b1;
        end
        else
        begin
            scl_sync   <= {scl_sync[`EEPROM_SYNC_STAGES-2:0], scl};
            sdata_sync <= {sdata_sync[`EEPROM_SYNC_STAGES-2:0], sdata};
            scl_q      <= scl_s;
            sdata_q    <= sdata_s;
        end
    end

    assign scl_s   = scl_sync[`EEPROM_SYNC_STAGES-1];
    assign sdata_s = sdata_sync[`EEPROM_SYNC_STAGES-1];

    // Registered event pulses, three cycles behind the pins
    always_ff @(posedge sda)
    begin
        if (reset)
        begin
            scl_rise   <= 1'b0;
            scl_fall   <= 1'b0;
            start_seen <= 1'b0;
            stop_seen  <= 1'b0;
        end
        else
        begin
            scl_rise   <= scl_s & ~scl_q;
            scl_fall   <= ~scl_s & scl_q;
            start_seen <= scl_s & scl_q & sdata_q & ~sdata_s;
            stop_seen  <= scl_s & scl_q & ~sdata_q & sdata_s;
        end
    end

    // sdata_q lines up with the sample that produced scl_rise
    assign next_word.data = {rx_word.data[`EEPROM_BYTE_BITS-2:0], sdata_q};

    assign receiving  = (state == st_control) || (state == st_address) ||
                        (state == st_write_data);
    assign byte_done  = scl_rise && receiving && (bit_cnt == 4'd7);
    assign device_ok  = (next_word.ctrl.device_type == `EEPROM_DEVICE_TYPE);
    assign ctrl_valid = (rx_word.ctrl.device_type == `EEPROM_DEVICE_TYPE);
    assign ack_now    = (state != st_control) || ctrl_valid;

    always_ff @(posedge sda)
    begin
        if (scl_rise && receiving && (bit_cnt < 4'd8))
        begin
            rx_word <= next_word;
        end
        if (byte_done && (state == st_write_data))
        begin
            wdata_q <= next_word.data;
        end
    end

    always_ff @(posedge sda)
    begin
        if (reset)
        begin
            state      <= st_idle;
            bit_cnt    <= 4'd0;
            ack_pull   <= 1'b0;
            master_ack <= 1'b0;
            write_q    <= 1'b0;
            bank_q     <= '0;
            addr_q     <= '0;
        end
        else
        begin
            write_q <= 1'b0;
            if (start_seen)
            begin
                state    <= st_control;   // A repeated start keeps the address
                bit_cnt  <= 4'd0;
                ack_pull <= 1'b0;
            end
            else if (stop_seen)
            begin
                state    <= st_idle;
                bit_cnt  <= 4'd0;
                ack_pull <= 1'b0;
            end
            else if (scl_rise && (state != st_idle))
            begin
                bit_cnt <= bit_cnt + 4'd1;
                if (byte_done)
                begin
                    case (state)
                        st_control:
                        begin
                            if (device_ok)
                            begin
                                bank_q <= next_word.ctrl.bank;
                            end
                        end
                        st_address:    addr_q  <= next_word.data;
                        st_write_data: write_q <= 1'b1;
                        default:       write_q <= 1'b0;
                    endcase
                end
                else if (bit_cnt == 4'd8)
                begin
                    // Address moves on during the acknowledge bit and wraps inside the bank
                    if ((state == st_write_data) || (state == st_read_ack))
                    begin
                        addr_q <= addr_q + 1'b1;
                    end
                    if (state == st_read_ack)
                    begin
                        master_ack <= ~sdata_q;
                    end
                end
            end
            else if (scl_fall)
            begin
                if ((bit_cnt == 4'd8) && receiving)
                begin
                    ack_pull <= ack_now;
                end
                else if ((bit_cnt == 4'd8) && (state == st_read_data))
                begin
                    state <= st_read_ack;   // Line is released for the master
                end
                else if (bit_cnt == 4'd9)
                begin
                    ack_pull <= 1'b0;
                    bit_cnt  <= 4'd0;
                    case (state)
                        st_control:
                        begin
                            if (!ctrl_valid)
                                state <= st_idle;
                            else if (rx_word.ctrl.read)
                                state <= st_read_data;
                            else
                                state <= st_address;
                        end
                        st_address:  state <= st_write_data;
                        st_read_ack: state <= master_ack ? st_read_data : st_idle;
                        default:     state <= state;
                    endcase
                end
            end
        end
    end

    // Loading on the event itself keeps the first data bit within four cycles of the pin
    assign load  = scl_fall && (bit_cnt == 4'd9) &&
                   (((state == st_control) && ctrl_valid && rx_word.ctrl.read) ||
                    ((state == st_read_ack) && master_ack));
    assign shift = scl_fall && (state == st_read_data) &&
                   (bit_cnt >= 4'd1) && (bit_cnt <= 4'd7);

    assign sdata_pull = (state == st_read_data) ? ~tx_bit : ack_pull;

    assign mem_req = '{write: write_q, bank: bank_q, addr: addr_q, wdata: wdata_q};

endmodule

`default_nettype wire

// File: rtl/eeprom_pkg.sv
`default_nettype none
`include "eeprom_config.svh"

package eeprom_pkg;

    // Control byte layout, most significant bit first on the wire
    typedef struct packed {
        logic [3:0]                   device_type;
        logic [`EEPROM_BANK_BITS-1:0] bank;
        logic                         read;   // 0 selects a write transfer
    } ctrl_fields_t;

    // The received byte is a control byte in the control phase and plain data afterwards
    typedef union packed {
        ctrl_fields_t                 ctrl;
        logic [`EEPROM_BYTE_BITS-1:0] data;
    } shift_word_t;

    // One request word seen by every bank and by the read selector
    typedef struct packed {
        logic                         write;  // Single-cycle strobe
        logic [`EEPROM_BANK_BITS-1:0] bank;
        logic [`EEPROM_ADDR_BITS-1:0] addr;
        logic [`EEPROM_BYTE_BITS-1:0] wdata;
    } mem_req_t;

endpackage

`default_nettype wire

// File: rtl/eeprom_config.svh
`ifndef EEPROM_CONFIG_SVH
`define EEPROM_CONFIG_SVH

// Memory organization, eight banks of 256 bytes for 2 KB in total
`define EEPROM_BANKS        8
`define EEPROM_BANK_BITS    3
`define EEPROM_BANK_DEPTH   256
`define EEPROM_ADDR_BITS    8
`define EEPROM_BYTE_BITS    8

// Upper nibble of every control byte this device answers to
`define EEPROM_DEVICE_TYPE  4'b1010

// Flops on scl and sdata before edge detection
`define EEPROM_SYNC_STAGES  2

`endif
